/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_y86_pipeline
FILELIST   = y86_pipeline.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* decode_stage.sv */
module decode_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  y86_pkg::decode_reg_t    d_reg,
    input  y86_pkg::reg_id_t        e_dst_e,
    input  y86_pkg::word_t          e_val_e,
    input  y86_pkg::memory_reg_t    m_reg,
    input  y86_pkg::word_t          m_val_m,
    input  y86_pkg::writeback_reg_t w_reg,
    output y86_pkg::reg_id_t        d_src_a,
    output y86_pkg::reg_id_t        d_src_b,
    output y86_pkg::execute_reg_t   e_in,
    output y86_pkg::reg_write_t     reg_write
);
    import y86_pkg::*;

    word_t rf_val_a;
    word_t rf_val_b;
    logic  w_ok;

    // Newest producer first
    function automatic word_t forward(input reg_id_t src, input word_t rf_val);
        if (src == reg_none) return rf_val;
        if (src == e_dst_e) return e_val_e;
        if (src == m_reg.dst_m) return m_val_m;
        if (src == m_reg.dst_e) return m_reg.val_e;
        if (src == w_reg.dst_m) return w_reg.val_m;
        if (src == w_reg.dst_e) return w_reg.val_e;
        return rf_val;
    endfunction

    assign w_ok = w_reg.stat == s_aok;
    assign reg_write.dst_e = w_ok ? w_reg.dst_e : reg_none;
    assign reg_write.val_e = w_reg.val_e;
    assign reg_write.dst_m = w_ok ? w_reg.dst_m : reg_none;
    assign reg_write.val_m = w_reg.val_m;

    register_file u_register_file (
        .clock (clock),
        .reset (reset),
        .write (reg_write),
        .src_a (d_src_a),
        .src_b (d_src_b),
        .val_a (rf_val_a),
        .val_b (rf_val_b)
    );

    assign d_src_a = (d_reg.icode inside {i_rrmovq, i_rmmovq, i_opq}) ? d_reg.ra : reg_none;
    assign d_src_b = (d_reg.icode inside {i_opq, i_rmmovq, i_mrmovq}) ? d_reg.rb : reg_none;

    always_comb begin
        e_in.stat  = d_reg.stat;
        e_in.icode = d_reg.icode;
        e_in.ifun  = d_reg.ifun;
        e_in.valc  = d_reg.valc;
        // Jump carries its fall-through for recovery
        e_in.vala  = (d_reg.icode == i_jxx) ? d_reg.valp : forward(d_src_a, rf_val_a);
        e_in.valb  = forward(d_src_b, rf_val_b);
        e_in.dst_e = (d_reg.icode inside {i_rrmovq, i_irmovq, i_opq}) ? d_reg.rb : reg_none;
        e_in.dst_m = (d_reg.icode == i_mrmovq) ? d_reg.ra : reg_none;
    end

endmodule

/* execute_stage.sv */
module execute_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  y86_pkg::execute_reg_t e_reg,
    input  y86_pkg::stat_t        m_stat,
    input  y86_pkg::stat_t        w_stat,
    output logic                  e_cnd,
    output y86_pkg::reg_id_t      e_dst_e,
    output y86_pkg::word_t        e_val_e,
    output y86_pkg::memory_reg_t  m_in
);
    import y86_pkg::*;

    localparam int msb = word_width - 1;

    word_t    alu_a;
    word_t    alu_b;
    alu_fun_t alu_fun;
    cc_t      cc;
    cc_t      new_cc;
    logic     set_cc;
    logic     lt;

    assign alu_a = (e_reg.icode inside {i_rrmovq, i_opq}) ? e_reg.vala : e_reg.valc;
    assign alu_b = (e_reg.icode inside {i_rrmovq, i_irmovq}) ? '0 : e_reg.valb;
    assign alu_fun = (e_reg.icode == i_opq) ? alu_fun_t'(e_reg.ifun) : alu_add;

    always_comb begin
        new_cc.of = 1'b0;
        case (alu_fun)
            alu_sub: begin
                e_val_e = alu_b - alu_a;
                new_cc.of = (alu_a[msb] != alu_b[msb]) && (e_val_e[msb] != alu_b[msb]);
            end
            alu_and: e_val_e = alu_b & alu_a;
            alu_xor: e_val_e = alu_b ^ alu_a;
            default: begin
                e_val_e = alu_b + alu_a;
                new_cc.of = (alu_a[msb] == alu_b[msb]) && (e_val_e[msb] != alu_a[msb]);
            end
        endcase
        new_cc.zf = e_val_e == '0;
        new_cc.sf = e_val_e[msb];
    end

    // Flags frozen once anything older has faulted
    assign set_cc = (e_reg.icode == i_opq) && !stat_is_exception(m_stat)
                    && !stat_is_exception(w_stat);

    always_ff @(posedge clock) begin
        if (reset) begin
            cc <= '{zf: 1'b1, sf: 1'b0, of: 1'b0};
        end else if (set_cc) begin
            cc <= new_cc;
        end
    end

    assign lt = cc.sf ^ cc.of;

    always_comb begin
        case (cond_t'(e_reg.ifun))
            c_always: e_cnd = 1'b1;
            c_le:     e_cnd = lt || cc.zf;
            c_l:      e_cnd = lt;
            c_e:      e_cnd = cc.zf;
            c_ne:     e_cnd = !cc.zf;
            c_ge:     e_cnd = !lt;
            c_g:      e_cnd = !lt && !cc.zf;
            default:  e_cnd = 1'b0;
        endcase
    end

    assign e_dst_e = (e_reg.icode == i_rrmovq && !e_cnd) ? reg_none : e_reg.dst_e;

    assign m_in = '{
        stat: e_reg.stat, icode: e_reg.icode, cnd: e_cnd, val_e: e_val_e,
        val_a: e_reg.vala, dst_e: e_dst_e, dst_m: e_reg.dst_m
    };

endmodule

/* fetch_stage.sv */
module fetch_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 f_stall,
    input  logic [79:0]          imem_bytes,
    input  y86_pkg::memory_reg_t m_reg,
    output y86_pkg::word_t       imem_addr,
    output y86_pkg::decode_reg_t f_out
);
    import y86_pkg::*;

    word_t                 pred_pc;
    word_t                 f_pc;
    word_t                 f_pred_next;
    logic [code_width-1:0] raw_icode;
    logic                  instr_valid;
    logic                  need_regids;
    logic                  need_valc;

    pipe_reg #(
        .payload_t    (word_t),
        .bubble_value ('0)
    ) u_pred_pc_reg (
        .clock  (clock),
        .reset  (reset),
        .stall  (f_stall),
        .bubble (1'b0),
        .d      (f_pred_next),
        .q      (pred_pc)
    );

    // Not-taken jump in M restarts at its fall-through address
    assign f_pc = (m_reg.icode == i_jxx && !m_reg.cnd) ? m_reg.val_a : pred_pc;
    assign imem_addr = f_pc;

    assign raw_icode   = imem_bytes[7:4];
    assign instr_valid = raw_icode <= 4'h7;
    assign need_regids = raw_icode inside {i_rrmovq, i_irmovq, i_rmmovq, i_mrmovq, i_opq};
    assign need_valc   = raw_icode inside {i_irmovq, i_rmmovq, i_mrmovq, i_jxx};

    always_comb begin
        f_out.icode = instr_valid ? icode_t'(raw_icode) : i_nop;
        f_out.ifun  = imem_bytes[3:0];
        f_out.ra    = need_regids ? imem_bytes[15:12] : reg_none;
        f_out.rb    = need_regids ? imem_bytes[11:8] : reg_none;
        f_out.valc  = need_regids ? imem_bytes[79:16] : imem_bytes[71:8];
        f_out.valp  = f_pc + 64'd1 + (need_regids ? 64'd1 : 64'd0)
                      + (need_valc ? 64'd8 : 64'd0);
        if (!instr_valid) begin
            f_out.stat = s_ins;
        end else if (raw_icode == i_halt) begin
            f_out.stat = s_hlt;
        end else begin
            f_out.stat = s_aok;
        end
    end

    // Jumps predicted taken
    assign f_pred_next = (f_out.icode == i_jxx) ? f_out.valc : f_out.valp;

endmodule

/* hazard_control.sv */
module hazard_control (
    input  y86_pkg::reg_id_t d_src_a,
    input  y86_pkg::reg_id_t d_src_b,
    input  y86_pkg::icode_t  e_icode,
    input  y86_pkg::reg_id_t e_dst_m,
    input  logic             e_cnd,
    input  y86_pkg::stat_t   m_stat,
    input  y86_pkg::stat_t   w_stat,
    output logic             f_stall,
    output logic             d_stall,
    output logic             d_bubble,
    output logic             e_bubble,
    output logic             m_bubble,
    output logic             w_stall
);
    import y86_pkg::*;

    logic load_use;
    logic mispredict;

    assign load_use = (e_icode == i_mrmovq) && (e_dst_m != reg_none)
                      && (e_dst_m == d_src_a || e_dst_m == d_src_b);

    // Jump in E was predicted taken
    assign mispredict = (e_icode == i_jxx) && !e_cnd;

    assign f_stall  = load_use;
    assign d_stall  = load_use;
    assign d_bubble = mispredict;
    assign e_bubble = mispredict || load_use;
    assign m_bubble = stat_is_exception(m_stat) || stat_is_exception(w_stat);
    assign w_stall  = stat_is_exception(w_stat);

endmodule

/* memory_stage.sv */
module memory_stage #(
    parameter int dmem_words = 64
) (
    input  logic                    clock,
    input  logic                    reset,
    input  y86_pkg::memory_reg_t    m_reg,
    output y86_pkg::stat_t          m_stat,
    output y86_pkg::word_t          m_val_m,
    output y86_pkg::writeback_reg_t w_in
);
    import y86_pkg::*;

    localparam int    index_width = $clog2(dmem_words);
    localparam word_t mem_bytes   = word_t'(8 * dmem_words);

    word_t                  mem [dmem_words];
    logic [index_width-1:0] word_index;
    logic                   mem_read;
    logic                   mem_write;
    logic                   addr_error;

    assign mem_read   = m_reg.icode == i_mrmovq;
    assign mem_write  = m_reg.icode == i_rmmovq;
    assign addr_error = (mem_read || mem_write) && (m_reg.val_e >= mem_bytes);
    assign word_index = m_reg.val_e[index_width+2:3];

    always_ff @(posedge clock) begin
        if (!reset && mem_write && !addr_error && m_reg.stat == s_aok) begin
            mem[word_index] <= m_reg.val_a;
        end
    end

    assign m_val_m = (mem_read && !addr_error) ? mem[word_index] : '0;
    assign m_stat  = addr_error ? s_adr : m_reg.stat;

    assign w_in = '{
        stat: m_stat, val_e: m_reg.val_e, val_m: m_val_m,
        dst_e: m_reg.dst_e, dst_m: m_reg.dst_m
    };

endmodule

/* pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic,
    parameter payload_t bubble_value = '0
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // Bubble wins over stall
    always_ff @(posedge clock) begin
        if (reset || bubble) begin
            q <= bubble_value;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* pipeline_input.txt */
# B addr len bytes | W reg value | S final stat (2 HLT, 3 ADR, 4 INS) | E run program
# All numbers hex, bytes listed in memory order
B 00 0a 30f00a00000000000000
B 0a 0a 30f30300000000000000
B 14 09 600361036230630300
W 0 a
W 3 3
W 3 d
W 3 3
W 0 2
W 3 1
S 2
E
B 00 0a 30f15500000000000000
B 0a 0a 30f20800000000000000
B 14 0a 40121000000000000000
B 1e 0a 50621000000000000000
B 28 03 606100
W 1 55
W 2 8
W 6 55
W 1 aa
S 2
E
B 00 0a 30f00100000000000000
B 0a 0a 30f30200000000000000
B 14 0b 6103734000000000000000
B 1f 09 743000000000000000
B 30 0b 30f8050000000000000000
B 40 0a 30f79900000000000000
W 0 1
W 3 2
W 3 1
W 8 5
S 2
E
B 00 0a 30f00400000000000000
B 0a 0a 30f30400000000000000
B 14 07 61032301240200
W 0 4
W 3 4
W 3 0
W 1 4
S 2
E
B 00 0a 30f00002000000000000
B 0a 0a 50300000000000000000
B 14 0a 30f10100000000000000
W 0 200
S 3
E
B 00 0b 30f0070000000000000090
B 0b 0a 30f30800000000000000
W 0 7
S 4
E

/* register_file.sv */
module register_file (
    input  logic                clock,
    input  logic                reset,
    input  y86_pkg::reg_write_t write,
    input  y86_pkg::reg_id_t    src_a,
    input  y86_pkg::reg_id_t    src_b,
    output y86_pkg::word_t      val_a,
    output y86_pkg::word_t      val_b
);
    import y86_pkg::*;

    word_t regs [0:14];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (write.dst_e != reg_none) begin
                regs[write.dst_e] <= write.val_e;
            end
            // Later assignment lets the M port win
            if (write.dst_m != reg_none) begin
                regs[write.dst_m] <= write.val_m;
            end
        end
    end

    assign val_a = (src_a == reg_none) ? '0 : regs[src_a];
    assign val_b = (src_b == reg_none) ? '0 : regs[src_b];

endmodule

/* tb_y86_pipeline.sv */
module tb_y86_pipeline;
    timeunit 1ns;
    timeprecision 1ps;

    import y86_pkg::*;

    localparam int imem_size      = 256;
    localparam int reset_cycles   = 5;
    localparam int cycle_limit    = 200;
    localparam int drain_cycles   = 4;
    localparam int max_line_bytes = 16;

    logic        clock;
    logic        reset;
    word_t       imem_addr;
    logic [79:0] imem_bytes;
    reg_write_t  reg_write;
    stat_t       stat;

    logic [7:0] imem [imem_size];
    reg_id_t    exp_reg [$];
    word_t      exp_val [$];
    stat_t      exp_stat;
    int         program_count;

    y86_pipeline #(.dmem_words(64)) u_y86_pipeline (
        .clock      (clock),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_bytes (imem_bytes),
        .reg_write  (reg_write),
        .stat       (stat)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Unused addresses read as halt
    function automatic logic [7:0] fetch_byte(input word_t addr);
        if (addr < word_t'(imem_size)) begin
            return imem[addr[7:0]];
        end
        return 8'h00;
    endfunction

    always_comb begin
        for (int i = 0; i < 10; i++) begin
            imem_bytes[8*i +: 8] = fetch_byte(imem_addr + word_t'(i));
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                                        $time, name, actual, expected));
        end
    endtask

    // Reset leaves bubbles everywhere and the PC at zero
    task automatic check_reset_state();
        check_value("imem_addr", imem_addr, '0);
        check_value("stat", word_t'(stat), word_t'(s_aok));
        check_value("reg_write.dst_e", word_t'(reg_write.dst_e), word_t'(reg_none));
        check_value("reg_write.dst_m", word_t'(reg_write.dst_m), word_t'(reg_none));
    endtask

    task automatic take_write(input string dst_name, input string val_name,
                              input reg_id_t dst, input word_t val);
        reg_id_t want_reg;
        word_t   want_val;
        if (exp_reg.size() == 0) begin
            stop_with_failure($sformatf("Unexpected write of %h to register %0d at time %0t",
                                        val, dst, $time));
        end else begin
            want_reg = exp_reg.pop_front();
            want_val = exp_val.pop_front();
            check_value(dst_name, word_t'(dst), word_t'(want_reg));
            check_value(val_name, val, want_val);
        end
    endtask

    // E port first, then M port
    task automatic watch_writes();
        if (reg_write.dst_e != reg_none) begin
            take_write("reg_write.dst_e", "reg_write.val_e", reg_write.dst_e, reg_write.val_e);
        end
        if (reg_write.dst_m != reg_none) begin
            take_write("reg_write.dst_m", "reg_write.val_m", reg_write.dst_m, reg_write.val_m);
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < imem_size; i++) begin
            imem[i] = 8'h00;
        end
        exp_reg.delete();
        exp_val.delete();
        exp_stat = s_aok;
    endtask

    // Data holds len bytes, first byte leftmost
    task automatic load_bytes(input word_t addr, input word_t len,
                              input logic [8*max_line_bytes-1:0] data);
        int idx;
        if (len > word_t'(max_line_bytes)) begin
            stop_with_failure("Byte line holds more bytes than the reader accepts");
        end
        for (int i = 0; i < int'(len); i++) begin
            idx = int'(addr) + i;
            if (idx >= imem_size) begin
                stop_with_failure("Program byte lies outside the instruction memory");
            end else begin
                imem[idx] = data[8*(int'(len)-1-i) +: 8];
            end
        end
    endtask

    task automatic run_program();
        int cycles;
        @(negedge clock);
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clock);
        check_reset_state();
        reset = 1'b0;
        cycles = 0;
        do begin
            @(negedge clock);
            watch_writes();
            cycles++;
            if (cycles > cycle_limit) begin
                stop_with_failure("Timeout: the program never left status AOK");
            end
        end while (stat == s_aok);
        check_value("stat", word_t'(stat), word_t'(exp_stat));
        // Nothing may write once the machine has stopped
        repeat (drain_cycles) begin
            @(negedge clock);
            watch_writes();
            check_value("stat", word_t'(stat), word_t'(exp_stat));
        end
        if (exp_reg.size() != 0) begin
            stop_with_failure($sformatf("Program %0d ended with %0d expected writes missing",
                                        program_count, exp_reg.size()));
        end
    endtask

    initial begin : main
        int                          fd;
        int                          n;
        string                       line;
        byte                         tag;
        word_t                       a;
        word_t                       b;
        logic [8*max_line_bytes-1:0] c;
        reset = 1'b1;
        program_count = 0;
        clear_program();
        fd = $fopen("pipeline_input.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open pipeline_input.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                tag = line.getc(0);
                line = line.substr(1, line.len() - 1);
                case (tag)
                    "B": begin
                        n = $sscanf(line, "%h %h %h", a, b, c);
                        load_bytes(a, b, c);
                    end
                    "W": begin
                        n = $sscanf(line, "%h %h", a, b);
                        exp_reg.push_back(reg_id_t'(a));
                        exp_val.push_back(b);
                    end
                    "S": begin
                        n = $sscanf(line, "%h", a);
                        exp_stat = stat_t'(a[2:0]);
                    end
                    "E": begin
                        run_program();
                        program_count++;
                        clear_program();
                    end
                    default: stop_with_failure("Unknown line type in pipeline_input.txt");
                endcase
            end
        end
        $fclose(fd);
        if (program_count > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("No program found in pipeline_input.txt");
        end
    end

endmodule

/* y86_pipeline.f */
y86_pkg.sv
pipe_reg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_control.sv
y86_pipeline.sv
y86_pipeline_sva.sv
tb_y86_pipeline.sv

/* y86_pipeline.sv */
module y86_pipeline #(
    parameter int dmem_words = 64
) (
    input  logic                clock,
    input  logic                reset,
    output y86_pkg::word_t      imem_addr,
    input  logic [79:0]         imem_bytes,
    output y86_pkg::reg_write_t reg_write,
    output y86_pkg::stat_t      stat
);
    import y86_pkg::*;

    decode_reg_t    f_out;
    decode_reg_t    d_reg;
    execute_reg_t   e_in;
    execute_reg_t   e_reg;
    memory_reg_t    m_in;
    memory_reg_t    m_reg;
    writeback_reg_t w_in;
    writeback_reg_t w_reg;
    reg_id_t        d_src_a;
    reg_id_t        d_src_b;
    reg_id_t        e_dst_e;
    word_t          e_val_e;
    logic           e_cnd;
    stat_t          m_stat;
    word_t          m_val_m;
    logic           f_stall;
    logic           d_stall;
    logic           d_bubble;
    logic           e_bubble;
    logic           m_bubble;
    logic           w_stall;

    fetch_stage u_fetch (
        .clock (clock), .reset (reset), .f_stall (f_stall), .imem_bytes (imem_bytes),
        .m_reg (m_reg), .imem_addr (imem_addr), .f_out (f_out)
    );

    pipe_reg #(.payload_t(decode_reg_t), .bubble_value(decode_bubble)) u_d_reg (
        .clock (clock), .reset (reset), .stall (d_stall), .bubble (d_bubble),
        .d (f_out), .q (d_reg)
    );

    decode_stage u_decode (
        .clock (clock), .reset (reset), .d_reg (d_reg), .e_dst_e (e_dst_e),
        .e_val_e (e_val_e), .m_reg (m_reg), .m_val_m (m_val_m), .w_reg (w_reg),
        .d_src_a (d_src_a), .d_src_b (d_src_b), .e_in (e_in), .reg_write (reg_write)
    );

    pipe_reg #(.payload_t(execute_reg_t), .bubble_value(execute_bubble)) u_e_reg (
        .clock (clock), .reset (reset), .stall (1'b0), .bubble (e_bubble),
        .d (e_in), .q (e_reg)
    );

    execute_stage u_execute (
        .clock (clock), .reset (reset), .e_reg (e_reg), .m_stat (m_stat),
        .w_stat (w_reg.stat), .e_cnd (e_cnd), .e_dst_e (e_dst_e),
        .e_val_e (e_val_e), .m_in (m_in)
    );

    pipe_reg #(.payload_t(memory_reg_t), .bubble_value(memory_bubble)) u_m_reg (
        .clock (clock), .reset (reset), .stall (1'b0), .bubble (m_bubble),
        .d (m_in), .q (m_reg)
    );

    memory_stage #(.dmem_words(dmem_words)) u_memory (
        .clock (clock), .reset (reset), .m_reg (m_reg), .m_stat (m_stat),
        .m_val_m (m_val_m), .w_in (w_in)
    );

    pipe_reg #(.payload_t(writeback_reg_t), .bubble_value(writeback_bubble)) u_w_reg (
        .clock (clock), .reset (reset), .stall (w_stall), .bubble (1'b0),
        .d (w_in), .q (w_reg)
    );

    hazard_control u_hazard (
        .d_src_a (d_src_a), .d_src_b (d_src_b), .e_icode (e_reg.icode),
        .e_dst_m (e_reg.dst_m), .e_cnd (e_cnd), .m_stat (m_stat), .w_stat (w_reg.stat),
        .f_stall (f_stall), .d_stall (d_stall), .d_bubble (d_bubble),
        .e_bubble (e_bubble), .m_bubble (m_bubble), .w_stall (w_stall)
    );

    // Bubbles look like normal operation from outside
    assign stat = (w_reg.stat == s_bub) ? s_aok : w_reg.stat;

endmodule

/* y86_pipeline_sva.sv */
module y86_pipeline_sva (
    input logic                 clock,
    input logic                 reset,
    input logic                 f_stall,
    input logic                 d_stall,
    input logic                 w_stall,
    input y86_pkg::word_t       imem_addr,
    input y86_pkg::decode_reg_t d_reg,
    input y86_pkg::stat_t       e_stat
);
    timeunit 1ns;
    timeprecision 1ps;

    import y86_pkg::*;

    // A stalled fetch keeps its PC and the instruction waiting in D
    stall_pair: assert property (@(posedge clock) disable iff (reset)
        f_stall |=> $stable(imem_addr) && $stable(d_reg))
        else $error("F stall did not hold the fetch PC and D register");

    // Load-use holds D and inserts a bubble behind it
    load_use_bubble: assert property (@(posedge clock) disable iff (reset)
        d_stall |=> e_stat == s_bub)
        else $error("load-use stall without E bubble");

    w_stall_sticky: assert property (@(posedge clock) disable iff (reset) !$fell(w_stall))
        else $error("W stall released without reset");

endmodule

// Stalls and stage registers all meet in the top level, where the clock is
bind y86_pipeline y86_pipeline_sva u_sva (
    .clock     (clock),
    .reset     (reset),
    .f_stall   (f_stall),
    .d_stall   (d_stall),
    .w_stall   (w_stall),
    .imem_addr (imem_addr),
    .d_reg     (d_reg),
    .e_stat    (e_reg.stat)
);

/* y86_pkg.sv */
package y86_pkg;

    localparam int word_width   = 64;
    localparam int reg_id_width = 4;
    localparam int code_width   = 4;

    typedef logic [word_width-1:0]   word_t;
    typedef logic [reg_id_width-1:0] reg_id_t;

    localparam reg_id_t reg_none = 4'hf;

    typedef enum logic [code_width-1:0] {
        i_halt   = 4'h0,
        i_nop    = 4'h1,
        i_rrmovq = 4'h2,
        i_irmovq = 4'h3,
        i_rmmovq = 4'h4,
        i_mrmovq = 4'h5,
        i_opq    = 4'h6,
        i_jxx    = 4'h7
    } icode_t;

    typedef enum logic [code_width-1:0] {
        alu_add = 4'h0,
        alu_sub = 4'h1,
        alu_and = 4'h2,
        alu_xor = 4'h3
    } alu_fun_t;

    // Shared by jXX and cmovXX
    typedef enum logic [code_width-1:0] {
        c_always = 4'h0,
        c_le     = 4'h1,
        c_l      = 4'h2,
        c_e      = 4'h3,
        c_ne     = 4'h4,
        c_ge     = 4'h5,
        c_g      = 4'h6
    } cond_t;

    typedef enum logic [2:0] {
        s_bub = 3'h0,
        s_aok = 3'h1,
        s_hlt = 3'h2,
        s_adr = 3'h3,
        s_ins = 3'h4
    } stat_t;

    typedef struct packed {
        logic zf;
        logic sf;
        logic of;
    } cc_t;

    typedef struct packed {
        stat_t                 stat;
        icode_t                icode;
        logic [code_width-1:0] ifun;
        reg_id_t               ra;
        reg_id_t               rb;
        word_t                 valc;
        word_t                 valp;
    } decode_reg_t;

    typedef struct packed {
        stat_t                 stat;
        icode_t                icode;
        logic [code_width-1:0] ifun;
        word_t                 valc;
        word_t                 vala;
        word_t                 valb;
        reg_id_t               dst_e;
        reg_id_t               dst_m;
    } execute_reg_t;

    typedef struct packed {
        stat_t   stat;
        icode_t  icode;
        logic    cnd;
        word_t   val_e;
        word_t   val_a;
        reg_id_t dst_e;
        reg_id_t dst_m;
    } memory_reg_t;

    typedef struct packed {
        stat_t   stat;
        word_t   val_e;
        word_t   val_m;
        reg_id_t dst_e;
        reg_id_t dst_m;
    } writeback_reg_t;

    typedef struct packed {
        reg_id_t dst_e;
        word_t   val_e;
        reg_id_t dst_m;
        word_t   val_m;
    } reg_write_t;

    localparam decode_reg_t decode_bubble = '{
        stat: s_bub, icode: i_nop, ifun: '0, ra: reg_none, rb: reg_none,
        valc: '0, valp: '0
    };

    localparam execute_reg_t execute_bubble = '{
        stat: s_bub, icode: i_nop, ifun: '0, valc: '0, vala: '0, valb: '0,
        dst_e: reg_none, dst_m: reg_none
    };

    localparam memory_reg_t memory_bubble = '{
        stat: s_bub, icode: i_nop, cnd: 1'b0, val_e: '0, val_a: '0,
        dst_e: reg_none, dst_m: reg_none
    };

    localparam writeback_reg_t writeback_bubble = '{
        stat: s_bub, val_e: '0, val_m: '0, dst_e: reg_none, dst_m: reg_none
    };

    // HLT, ADR and INS all stop the machine
    function automatic logic stat_is_exception(input stat_t s);
        return (s == s_hlt) || (s == s_adr) || (s == s_ins);
    endfunction

endpackage
